// ==== hw/periph_pkg.sv ====
// Shared definitions for the peripheral subsystem
// Address map and window numbers of the register port
// Register offsets inside the PLIC and timer windows
// Data, address, priority and source ID widths
package periph_pkg;

    // ---------------------------------------------------------------------------
    // Register port
    // ---------------------------------------------------------------------------
    localparam int unsigned ADDR_W = 16;
    localparam int unsigned DATA_W = 32;

    // Window field in the address, word offset below it
    localparam int unsigned SLOT_LSB = 12;
    localparam int unsigned SLOT_W   = 4;
    localparam int unsigned OFF_LSB  = 2;
    localparam int unsigned OFF_W    = SLOT_LSB - OFF_LSB;

    localparam logic [SLOT_W-1:0] SLOT_PLIC  = 4'd0;
    localparam logic [SLOT_W-1:0] SLOT_TIMER = 4'd1;
    localparam logic [SLOT_W-1:0] SLOT_SPI   = 4'd2;
    localparam logic [SLOT_W-1:0] SLOT_ETH   = 4'd3;

    // Read word of the error responder
    localparam logic [DATA_W-1:0] ERR_RDATA = 32'hDEADBEEF;

    // ---------------------------------------------------------------------------
    // PLIC
    // ---------------------------------------------------------------------------
    localparam int unsigned N_SRC    = 4;
    // ID 0 is reserved for "no source"
    localparam int unsigned SRC_ID_W = $clog2(N_SRC + 1);
    localparam int unsigned MAX_PRIO = 7;
    localparam int unsigned PRIO_W   = $clog2(MAX_PRIO + 1);

    // Word offsets, one priority word per source starting at PLIC_PRIO0
    localparam int unsigned PLIC_PRIO0     = 0;
    localparam int unsigned PLIC_PENDING   = 4;
    localparam int unsigned PLIC_ENABLE    = 5;
    localparam int unsigned PLIC_THRESHOLD = 6;
    localparam int unsigned PLIC_CLAIM     = 7;

    // ---------------------------------------------------------------------------
    // Timers
    // ---------------------------------------------------------------------------
    localparam int unsigned N_TIMER = 2;
    localparam int unsigned TMR_W   = 32;

    // Word offsets within one timer, timer n starts at n * TMR_STRIDE
    localparam int unsigned TMR_COUNT  = 0;
    localparam int unsigned TMR_CMP    = 1;
    localparam int unsigned TMR_CTRL   = 2;
    localparam int unsigned TMR_STATUS = 3;
    localparam int unsigned TMR_STRIDE = 4;

endpackage

// ==== hw/periph_decode.sv ====
// Address decoder for the register port
// Window select pulses, registered read mux and acknowledge,
// error response for stubbed and unmapped windows
`timescale 1ns/1ps

module periph_decode import periph_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic              ack_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              err_o,
    output logic              plic_sel_o,
    output logic              tmr_sel_o,
    output logic              we_o,
    output logic [OFF_W-1:0]  off_o,
    output logic [DATA_W-1:0] wdata_o,
    input  logic [DATA_W-1:0] plic_rdata_i,
    input  logic [DATA_W-1:0] tmr_rdata_i
);

    logic [SLOT_W-1:0] slot;
    logic              plic_hit;
    logic              tmr_hit;
    logic              err_d;
    logic [DATA_W-1:0] rdata_d;

    assign slot  = addr_i[SLOT_LSB +: SLOT_W];
    assign off_o = addr_i[OFF_LSB +: OFF_W];

    always_comb begin
        plic_hit = 1'b0;
        tmr_hit  = 1'b0;
        case (slot)
            SLOT_PLIC:  plic_hit = 1'b1;
            SLOT_TIMER: tmr_hit  = 1'b1;
            // SPI and Ethernet are stubs, they share the error path
            SLOT_SPI, SLOT_ETH: ;
            default: ;
        endcase
    end

    // Only a mapped window sees the access, so stub writes are dropped
    assign plic_sel_o = req_i & plic_hit;
    assign tmr_sel_o  = req_i & tmr_hit;
    assign we_o       = we_i;
    assign wdata_o    = wdata_i;

    // ---------------------------------------------------------------------------
    // Response for the next cycle
    // ---------------------------------------------------------------------------
    assign err_d = req_i & ~(plic_hit | tmr_hit);

    always_comb begin
        rdata_d = '0;
        if (err_d) begin
            rdata_d = ERR_RDATA;
        end else if (req_i && !we_i) begin
            if (plic_hit) begin
                rdata_d = plic_rdata_i;
            end else begin
                rdata_d = tmr_rdata_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
            rdata_o <= '0;
        end else begin
            ack_o   <= req_i;
            err_o   <= err_d;
            rdata_o <= rdata_d;
        end
    end

endmodule

// ==== hw/periph_timer.sv ====
// Two compare timers behind the timer window
// Count, compare, control and status registers per timer
// Sticky match flags that drive the timer interrupts
`timescale 1ns/1ps

module periph_timer import periph_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               sel_i,
    input  logic               we_i,
    input  logic [OFF_W-1:0]   off_i,
    input  logic [DATA_W-1:0]  wdata_i,
    output logic [DATA_W-1:0]  rdata_o,
    output logic [N_TIMER-1:0] irq_o
);

    logic [N_TIMER-1:0][TMR_W-1:0] count_q;
    logic [N_TIMER-1:0][TMR_W-1:0] cmp_q;
    logic [N_TIMER-1:0]            en_q;
    logic [N_TIMER-1:0]            status_q;

    for (genvar t = 0; t < N_TIMER; t++) begin : gen_timer
        localparam int unsigned BASE = t * TMR_STRIDE;

        logic wr_count;
        logic wr_cmp;
        logic wr_ctrl;
        logic wr_status;
        logic match;

        assign wr_count  = sel_i && we_i && (off_i == OFF_W'(BASE + TMR_COUNT));
        assign wr_cmp    = sel_i && we_i && (off_i == OFF_W'(BASE + TMR_CMP));
        assign wr_ctrl   = sel_i && we_i && (off_i == OFF_W'(BASE + TMR_CTRL));
        assign wr_status = sel_i && we_i && (off_i == OFF_W'(BASE + TMR_STATUS));
        assign match     = en_q[t] && (count_q[t] == cmp_q[t]);

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                count_q[t]  <= '0;
                cmp_q[t]    <= '0;
                en_q[t]     <= 1'b0;
                status_q[t] <= 1'b0;
            end else begin
                // A software write to the count wins over the counter
                if (wr_count) begin
                    count_q[t] <= wdata_i[TMR_W-1:0];
                end else if (match) begin
                    count_q[t] <= '0;
                end else if (en_q[t]) begin
                    count_q[t] <= count_q[t] + 1'b1;
                end

                if (wr_cmp) begin
                    cmp_q[t] <= wdata_i[TMR_W-1:0];
                end
                if (wr_ctrl) begin
                    en_q[t] <= wdata_i[0];
                end

                // Write one to clear, a match in the same cycle keeps it set
                if (match) begin
                    status_q[t] <= 1'b1;
                end else if (wr_status && wdata_i[0]) begin
                    status_q[t] <= 1'b0;
                end
            end
        end
    end

    assign irq_o = status_q;

    // Read mux, unmapped offsets return zero
    always_comb begin
        rdata_o = '0;
        for (int t = 0; t < N_TIMER; t++) begin
            if (off_i == OFF_W'(t * TMR_STRIDE + TMR_COUNT)) begin
                rdata_o = DATA_W'(count_q[t]);
            end
            if (off_i == OFF_W'(t * TMR_STRIDE + TMR_CMP)) begin
                rdata_o = DATA_W'(cmp_q[t]);
            end
            if (off_i == OFF_W'(t * TMR_STRIDE + TMR_CTRL)) begin
                rdata_o = DATA_W'(en_q[t]);
            end
            if (off_i == OFF_W'(t * TMR_STRIDE + TMR_STATUS)) begin
                rdata_o = DATA_W'(status_q[t]);
            end
        end
    end

endmodule

// ==== hw/plic_gateway.sv ====
// PLIC gateway for level-triggered sources
// Pending and in-service bits per source, updated by claim and complete
`timescale 1ns/1ps

module plic_gateway import periph_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [N_SRC-1:0]    src_i,
    input  logic                claim_i,
    input  logic [SRC_ID_W-1:0] claim_id_i,
    input  logic                complete_i,
    input  logic [SRC_ID_W-1:0] complete_id_i,
    output logic [N_SRC-1:0]    pending_o
);

    logic [N_SRC-1:0] pending_q;
    logic [N_SRC-1:0] in_service_q;
    logic [N_SRC-1:0] claim_hit;
    logic [N_SRC-1:0] complete_hit;

    // Source IDs start at 1, bit i holds source i+1
    always_comb begin
        for (int i = 0; i < N_SRC; i++) begin
            claim_hit[i]    = claim_i && (claim_id_i == SRC_ID_W'(i + 1));
            complete_hit[i] = complete_i && (complete_id_i == SRC_ID_W'(i + 1));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            for (int i = 0; i < N_SRC; i++) begin
                if (claim_hit[i]) begin
                    pending_q[i]    <= 1'b0;
                    in_service_q[i] <= 1'b1;
                end else begin
                    if (complete_hit[i]) begin
                        in_service_q[i] <= 1'b0;
                    end
                    // Held level re-arms one cycle after the complete
                    if (src_i[i] && !in_service_q[i]) begin
                        pending_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    assign pending_o = pending_q;

endmodule

// ==== hw/plic_target.sv ====
// PLIC target for a single hart context
// Priority, enable and threshold registers
// Highest-priority selection, claim/complete register, target interrupt
`timescale 1ns/1ps

module plic_target import periph_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                sel_i,
    input  logic                we_i,
    input  logic [OFF_W-1:0]    off_i,
    input  logic [DATA_W-1:0]   wdata_i,
    input  logic [N_SRC-1:0]    pending_i,
    output logic [DATA_W-1:0]   rdata_o,
    output logic                claim_o,
    output logic [SRC_ID_W-1:0] claim_id_o,
    output logic                complete_o,
    output logic [SRC_ID_W-1:0] complete_id_o,
    output logic                irq_o
);

    logic [N_SRC-1:0][PRIO_W-1:0] prio_q;
    logic [N_SRC-1:0]             enable_q;
    logic [PRIO_W-1:0]            threshold_q;
    logic [SRC_ID_W-1:0]          best_id;
    logic [PRIO_W-1:0]            best_prio;
    logic                         claim_acc;

    // ---------------------------------------------------------------------------
    // Source selection
    // ---------------------------------------------------------------------------
    // Strict compare from ID 1 up, so ties go to the lower ID and prio 0 never wins
    always_comb begin
        best_id   = '0;
        best_prio = '0;
        for (int i = 0; i < N_SRC; i++) begin
            if (pending_i[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
                best_id   = SRC_ID_W'(i + 1);
                best_prio = prio_q[i];
            end
        end
    end

    // Claim on read, complete on write of the claim word
    assign claim_acc     = sel_i && (off_i == OFF_W'(PLIC_CLAIM));
    assign claim_o       = claim_acc && !we_i;
    assign claim_id_o    = best_id;
    assign complete_o    = claim_acc && we_i;
    assign complete_id_o = wdata_i[SRC_ID_W-1:0];

    // ---------------------------------------------------------------------------
    // Registers
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q      <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
            irq_o       <= 1'b0;
        end else begin
            irq_o <= (best_prio > threshold_q);
            if (sel_i && we_i) begin
                for (int i = 0; i < N_SRC; i++) begin
                    if (off_i == OFF_W'(PLIC_PRIO0 + i)) begin
                        prio_q[i] <= wdata_i[PRIO_W-1:0];
                    end
                end
                if (off_i == OFF_W'(PLIC_ENABLE)) begin
                    enable_q <= wdata_i[N_SRC-1:0];
                end
                if (off_i == OFF_W'(PLIC_THRESHOLD)) begin
                    threshold_q <= wdata_i[PRIO_W-1:0];
                end
            end
        end
    end

    // Read mux, the pending word is read only
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < N_SRC; i++) begin
            if (off_i == OFF_W'(PLIC_PRIO0 + i)) begin
                rdata_o = DATA_W'(prio_q[i]);
            end
        end
        if (off_i == OFF_W'(PLIC_PENDING)) begin
            rdata_o = DATA_W'(pending_i);
        end
        if (off_i == OFF_W'(PLIC_ENABLE)) begin
            rdata_o = DATA_W'(enable_q);
        end
        if (off_i == OFF_W'(PLIC_THRESHOLD)) begin
            rdata_o = DATA_W'(threshold_q);
        end
        if (off_i == OFF_W'(PLIC_CLAIM)) begin
            rdata_o = DATA_W'(best_id);
        end
    end

endmodule

// ==== hw/periph_top.sv ====
// Peripheral subsystem top level
// Register port decoder, two compare timers and a four-source PLIC
`timescale 1ns/1ps

module periph_top import periph_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     req_i,
    input  logic                     we_i,
    input  logic [ADDR_W-1:0]        addr_i,
    input  logic [DATA_W-1:0]        wdata_i,
    output logic                     ack_o,
    output logic [DATA_W-1:0]        rdata_o,
    output logic                     err_o,
    input  logic [N_SRC-N_TIMER-1:0] ext_irq_i,
    output logic                     irq_o
);

    logic                plic_sel;
    logic                tmr_sel;
    logic                we;
    logic [OFF_W-1:0]    off;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W-1:0]   plic_rdata;
    logic [DATA_W-1:0]   tmr_rdata;
    logic [N_TIMER-1:0]  tmr_irq;
    logic [N_SRC-1:0]    pending;
    logic                claim;
    logic [SRC_ID_W-1:0] claim_id;
    logic                complete;
    logic [SRC_ID_W-1:0] complete_id;

    // ---------------------------------------------------------------------------
    // Register port
    // ---------------------------------------------------------------------------
    periph_decode periph_decode_i (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .req_i        ( req_i      ),
        .we_i         ( we_i       ),
        .addr_i       ( addr_i     ),
        .wdata_i      ( wdata_i    ),
        .ack_o        ( ack_o      ),
        .rdata_o      ( rdata_o    ),
        .err_o        ( err_o      ),
        .plic_sel_o   ( plic_sel   ),
        .tmr_sel_o    ( tmr_sel    ),
        .we_o         ( we         ),
        .off_o        ( off        ),
        .wdata_o      ( wdata      ),
        .plic_rdata_i ( plic_rdata ),
        .tmr_rdata_i  ( tmr_rdata  )
    );

    periph_timer periph_timer_i (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .sel_i   ( tmr_sel   ),
        .we_i    ( we        ),
        .off_i   ( off       ),
        .wdata_i ( wdata     ),
        .rdata_o ( tmr_rdata ),
        .irq_o   ( tmr_irq   )
    );

    // ---------------------------------------------------------------------------
    // PLIC, sources 1-2 are the timers and 3-4 the external inputs
    // ---------------------------------------------------------------------------
    plic_gateway plic_gateway_i (
        .clk_i         ( clk_i                ),
        .rst_n_i       ( rst_n_i              ),
        .src_i         ( {ext_irq_i, tmr_irq} ),
        .claim_i       ( claim                ),
        .claim_id_i    ( claim_id             ),
        .complete_i    ( complete             ),
        .complete_id_i ( complete_id          ),
        .pending_o     ( pending              )
    );

    plic_target plic_target_i (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .sel_i         ( plic_sel    ),
        .we_i          ( we          ),
        .off_i         ( off         ),
        .wdata_i       ( wdata       ),
        .pending_i     ( pending     ),
        .rdata_o       ( plic_rdata  ),
        .claim_o       ( claim       ),
        .claim_id_o    ( claim_id    ),
        .complete_o    ( complete    ),
        .complete_id_o ( complete_id ),
        .irq_o         ( irq_o       )
    );

endmodule

// ==== bench/periph_props.sv ====
// Concurrent properties of the peripheral register port
// Acknowledge timing, error qualification, interrupt during reset
`timescale 1ns/1ps

module periph_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_i,
    input logic ack_i,
    input logic err_i,
    input logic irq_i
);

    // One acknowledge per request exactly one cycle later
    ack_follows_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) ack_i == $past(req_i)
    ) else $error("ack_o does not match req_i of the previous cycle");

    err_needs_ack: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) err_i |-> ack_i
    ) else $error("err_o is high without ack_o");

    // Interrupt output held low while reset is asserted
    irq_low_in_reset: assert property (
        @(posedge clk_i) !rst_n_i |-> !irq_i
    ) else $error("irq_o is high while reset is asserted");

endmodule

// ==== bench/periph_tb.sv ====
// Testbench for the peripheral subsystem
// Clock and reset, a table of register port steps applied in a loop,
// value checks on the port and the interrupt output, cycle limit
`timescale 1ns/1ps

module periph_tb import periph_pkg::*; ();

    localparam int K_WR    = 0;
    localparam int K_RD    = 1;
    localparam int K_POLL  = 2;
    localparam int IRQ_ANY = 2;
    localparam int CMP_C   = 10;
    localparam logic [DATA_W-1:0] FULL = '1;

    logic              clk_i;
    logic              rst_n_i;
    logic              req_i;
    logic              we_i;
    logic [ADDR_W-1:0] addr_i;
    logic [DATA_W-1:0] wdata_i;
    logic              ack_o;
    logic [DATA_W-1:0] rdata_o;
    logic              err_o;
    logic [1:0]        ext_irq_i;
    logic              irq_o;

    // Step table with one entry per queue index
    int                step_kind[$];
    logic [ADDR_W-1:0] step_addr[$];
    logic [DATA_W-1:0] step_wdata[$];
    logic [DATA_W-1:0] step_mask[$];
    logic [DATA_W-1:0] step_exp[$];
    logic              step_err[$];
    int                step_irq[$];
    logic [1:0]        step_ext[$];
    int                step_limit[$];

    int unsigned cycles = 0;
    int unsigned max_cycles;
    int          errors;
    int          checks;

    periph_top periph_top_i (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .req_i     ( req_i     ),
        .we_i      ( we_i      ),
        .addr_i    ( addr_i    ),
        .wdata_i   ( wdata_i   ),
        .ack_o     ( ack_o     ),
        .rdata_o   ( rdata_o   ),
        .err_o     ( err_o     ),
        .ext_irq_i ( ext_irq_i ),
        .irq_o     ( irq_o     )
    );

    bind periph_top periph_props periph_props_i (
        .clk_i   ( clk_i   ),
        .rst_n_i ( rst_n_i ),
        .req_i   ( req_i   ),
        .ack_i   ( ack_o   ),
        .err_i   ( err_o   ),
        .irq_i   ( irq_o   )
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, the run was stopped", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // ---------------------------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------------------------
    function automatic logic [ADDR_W-1:0] win_addr(input logic [SLOT_W-1:0] slot,
                                                   input int unsigned off);
        return (ADDR_W'(slot) << SLOT_LSB) | ADDR_W'(off << 2);
    endfunction

    function automatic logic [ADDR_W-1:0] plic_addr(input int unsigned off);
        return win_addr(SLOT_PLIC, off);
    endfunction

    function automatic logic [ADDR_W-1:0] tmr_addr(input int unsigned t, input int unsigned off);
        return win_addr(SLOT_TIMER, t * TMR_STRIDE + off);
    endfunction

    task automatic add_step(input int kind, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] mask,
                            input logic [DATA_W-1:0] exp, input logic err, input int irq,
                            input logic [1:0] ext, input int limit);
        step_kind.push_back(kind);
        step_addr.push_back(addr);
        step_wdata.push_back(wdata);
        step_mask.push_back(mask);
        step_exp.push_back(exp);
        step_err.push_back(err);
        step_irq.push_back(irq);
        step_ext.push_back(ext);
        step_limit.push_back(limit);
    endtask

    // A write answers with zero or with the error word on a dead window
    task automatic add_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic err, input int irq);
        add_step(K_WR, addr, wdata, FULL, err ? ERR_RDATA : '0, err, irq, 2'b00, 0);
    endtask

    task automatic add_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] mask,
                            input logic [DATA_W-1:0] exp, input logic err, input int irq);
        add_step(K_RD, addr, '0, mask, exp, err, irq, 2'b00, 0);
    endtask

    task automatic add_poll(input logic [1:0] ext, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] mask, input logic [DATA_W-1:0] exp,
                            input int limit, input int irq);
        add_step(K_POLL, addr, '0, mask, exp, 1'b0, irq, ext, limit);
    endtask

    task automatic port_access(input logic we, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata);
        @(posedge clk_i);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        wdata_i <= wdata;
        @(posedge clk_i);
        req_i <= 1'b0;
        we_i  <= 1'b0;
        // Registered response is sampled on the falling edge
        @(negedge clk_i);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    // ---------------------------------------------------------------------------
    // Stimulus table
    // ---------------------------------------------------------------------------
    task automatic build_table();
        // Stub and unmapped windows followed by reads that show their writes were dropped
        add_write(win_addr(SLOT_SPI, 1), 32'h0000_0055, 1'b1, IRQ_ANY);
        add_read(win_addr(SLOT_SPI, 1), FULL, ERR_RDATA, 1'b1, IRQ_ANY);
        add_write(win_addr(SLOT_ETH, TMR_CMP), 32'h0000_1234, 1'b1, IRQ_ANY);
        add_read(win_addr(SLOT_ETH, 0), FULL, ERR_RDATA, 1'b1, IRQ_ANY);
        add_write(win_addr(4'h9, PLIC_THRESHOLD), 32'h0000_0007, 1'b1, IRQ_ANY);
        add_read(win_addr(4'hF, 0), FULL, ERR_RDATA, 1'b1, 0);
        add_read(plic_addr(PLIC_THRESHOLD), FULL, 32'h0, 1'b0, IRQ_ANY);
        add_read(tmr_addr(0, TMR_CMP), FULL, 32'h0, 1'b0, IRQ_ANY);
        add_read(tmr_addr(0, TMR_CTRL), FULL, 32'h0, 1'b0, IRQ_ANY);
        // Register widths
        add_write(plic_addr(PLIC_PRIO0), 32'hFFFF_FFFD, 1'b0, IRQ_ANY);
        add_read(plic_addr(PLIC_PRIO0), FULL, 32'h5, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_ENABLE), 32'h0000_00A5, 1'b0, IRQ_ANY);
        add_read(plic_addr(PLIC_ENABLE), FULL, 32'h5, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_THRESHOLD), 32'h0000_001E, 1'b0, IRQ_ANY);
        add_read(plic_addr(PLIC_THRESHOLD), FULL, 32'h6, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_PENDING), 32'h0000_000F, 1'b0, IRQ_ANY);
        add_read(plic_addr(PLIC_PENDING), FULL, 32'h0, 1'b0, IRQ_ANY);
        add_write(tmr_addr(1, TMR_CMP), 32'hCAFE_0001, 1'b0, IRQ_ANY);
        add_read(tmr_addr(1, TMR_CMP), FULL, 32'hCAFE_0001, 1'b0, IRQ_ANY);
        add_write(tmr_addr(1, TMR_CTRL), 32'hFFFF_FFFF, 1'b0, IRQ_ANY);
        add_read(tmr_addr(1, TMR_CTRL), FULL, 32'h1, 1'b0, IRQ_ANY);
        add_write(tmr_addr(1, TMR_CTRL), 32'h0000_0002, 1'b0, IRQ_ANY);
        add_read(tmr_addr(1, TMR_CTRL), FULL, 32'h0, 1'b0, IRQ_ANY);
        // Timer 0 is source 1
        add_write(plic_addr(PLIC_PRIO0), 32'h3, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_ENABLE), 32'h1, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_THRESHOLD), 32'h1, 1'b0, 0);
        add_write(tmr_addr(0, TMR_CMP), CMP_C, 1'b0, IRQ_ANY);
        add_write(tmr_addr(0, TMR_CTRL), 32'h1, 1'b0, IRQ_ANY);
        add_poll(2'b00, tmr_addr(0, TMR_STATUS), 32'h1, 32'h1, CMP_C + 4, IRQ_ANY);
        add_read(plic_addr(PLIC_PENDING), FULL, 32'h1, 1'b0, 1);
        add_write(tmr_addr(0, TMR_CTRL), 32'h0, 1'b0, IRQ_ANY);
        add_write(tmr_addr(0, TMR_STATUS), 32'h1, 1'b0, IRQ_ANY);
        add_read(tmr_addr(0, TMR_STATUS), FULL, 32'h0, 1'b0, IRQ_ANY);
        add_read(plic_addr(PLIC_CLAIM), FULL, 32'h1, 1'b0, 0);
        add_write(plic_addr(PLIC_CLAIM), 32'h1, 1'b0, IRQ_ANY);
        add_read(plic_addr(PLIC_PENDING), FULL, 32'h0, 1'b0, 0);
        // External sources with source 4 above source 3
        add_write(plic_addr(PLIC_PRIO0 + 2), 32'h2, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_PRIO0 + 3), 32'h5, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_ENABLE), 32'hC, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_THRESHOLD), 32'h0, 1'b0, IRQ_ANY);
        add_poll(2'b11, plic_addr(PLIC_PENDING), 32'hC, 32'hC, 8, 1);
        add_read(plic_addr(PLIC_CLAIM), FULL, 32'h4, 1'b0, 1);
        add_read(plic_addr(PLIC_CLAIM), FULL, 32'h3, 1'b0, 0);
        add_read(plic_addr(PLIC_CLAIM), FULL, 32'h0, 1'b0, 0);
        add_write(plic_addr(PLIC_CLAIM), 32'h4, 1'b0, IRQ_ANY);
        add_read(plic_addr(PLIC_CLAIM), FULL, 32'h4, 1'b0, IRQ_ANY);
        // Threshold at or above every pending priority
        add_write(plic_addr(PLIC_THRESHOLD), 32'h7, 1'b0, 0);
        add_write(plic_addr(PLIC_CLAIM), 32'h4, 1'b0, IRQ_ANY);
        add_write(plic_addr(PLIC_CLAIM), 32'h3, 1'b0, IRQ_ANY);
        add_poll(2'b11, plic_addr(PLIC_PENDING), 32'hC, 32'hC, 8, 0);
        add_write(plic_addr(PLIC_THRESHOLD), 32'h5, 1'b0, 0);
        add_write(plic_addr(PLIC_THRESHOLD), 32'h4, 1'b0, 1);
        add_poll(2'b00, plic_addr(PLIC_THRESHOLD), FULL, 32'h4, 8, 1);
    endtask

    // ---------------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------------
    initial begin
        int cyc;
        rst_n_i   = 1'b0;
        req_i     = 1'b0;
        we_i      = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        ext_irq_i = 2'b00;
        errors    = 0;
        checks    = 0;
        build_table();
        max_cycles = step_kind.size() * 64;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;

        for (int i = 0; i < step_kind.size(); i++) begin
            if (step_kind[i] == K_POLL) begin
                @(posedge clk_i);
                ext_irq_i <= step_ext[i];
                cyc = 1;
                do begin
                    port_access(1'b0, step_addr[i], '0);
                    cyc += 2;
                end while (((rdata_o & step_mask[i]) !== step_exp[i]) && cyc <= step_limit[i]);
                checks++;
                assert ((rdata_o & step_mask[i]) === step_exp[i]) else begin
                    errors++;
                    $display("Step %0d polled address %h for %0d cycles without a match",
                             i, step_addr[i], cyc);
                end
            end else begin
                port_access(step_kind[i] == K_WR, step_addr[i], step_wdata[i]);
            end
            check_value("ack_o", 32'h1, DATA_W'(ack_o));
            check_value("err_o", DATA_W'(step_err[i]), DATA_W'(err_o));
            check_value("rdata_o", step_exp[i], rdata_o & step_mask[i]);
            // irq_o is registered behind the state it follows
            if (step_irq[i] != IRQ_ANY) begin
                @(posedge clk_i);
                @(negedge clk_i);
                check_value("irq_o", DATA_W'(step_irq[i]), DATA_W'(irq_o));
            end
        end

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/periph_pkg.sv
hw/periph_decode.sv
hw/periph_timer.sv
hw/plic_gateway.sv
hw/plic_target.sv
hw/periph_top.sv
bench/periph_props.sv
bench/periph_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the peripheral subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module periph_tb -o Vperiph_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vperiph_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^All tests passed$"; then
    exit 0
fi
exit 1
